// File: Bender.yml
package:
  name: l1mem

sources:
  - include_dirs:
      - include
    files:
      - logic/l1memPkg.sv
      - logic/instCache.sv
      - logic/dataCache.sv
      - logic/accessGuard.sv
      - logic/l1Arbiter.sv
      - logic/l1Memory.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/backingStore.sv
      - verification/l1MemoryTb.sv

// File: include/l1mem_defs.svh
//**********************************************************
// Sizes and reset values shared by the L1 memory RTL.
// Include it in any file that sizes a port, an array or a
// guard register. The package includes it for its structs.
//**********************************************************
`ifndef L1MEM_DEFS_SVH
`define L1MEM_DEFS_SVH

`define ADDR_WIDTH			48		// byte address
`define LINE_WIDTH			128		// one memory line, two words
`define WORD_WIDTH			64		// fetch or data word
`define LINE_OFFSET_BITS	4		// byte offset inside a line

`define IC_SETS				64
`define IC_INDEX_BITS		6		// log2 of IC_SETS
`define DC_SETS				64
`define DC_INDEX_BITS		6		// log2 of DC_SETS

// base == limit, so the window starts out empty
`define GUARD_RESET_BASE	48'h0
`define GUARD_RESET_LIMIT	48'h0

`endif

// File: l1mem.f
+incdir+include
logic/l1memPkg.sv
logic/instCache.sv
logic/dataCache.sv
logic/accessGuard.sv
logic/l1Arbiter.sv
logic/l1Memory.sv
verification/backingStore.sv
verification/l1MemoryTb.sv

// File: logic/accessGuard.sv
//**********************************************************
// Access guard for one protected address window.
// cfgIndex 0 writes the base, 1 the limit, 2 the flags.
// Flags apply to base <= addr < limit, else zero.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module accessGuard
	import l1memPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic					cfgWrite,
	input	logic [1:0]				cfgIndex,
	input	logic [`ADDR_WIDTH-1:0]	cfgData,
	input	logic [`ADDR_WIDTH-1:0]	reqAddr,	// arbiter's selected request
	output	accessFlags				flags
);

	logic [`ADDR_WIDTH-1:0]	winBase;
	logic [`ADDR_WIDTH-1:0]	winLimit;	// exclusive
	accessFlags				winFlags;
	logic					inWindow;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			winBase		<= `GUARD_RESET_BASE;
			winLimit	<= `GUARD_RESET_LIMIT;
			winFlags	<= '0;
		end
		else if (cfgWrite)
		begin
			case (cfgIndex)
				2'd0:		winBase		<= cfgData;
				2'd1:		winLimit	<= cfgData;
				2'd2:		winFlags	<= cfgData[2:0];	// noRead, noWrite, noExec
				default:	;	// index 3 unused
			endcase
		end
	end

	assign inWindow	= (reqAddr >= winBase) && (reqAddr < winLimit);
	assign flags	= inWindow ? winFlags : '0;

endmodule

// File: logic/dataCache.sv
//**********************************************************
// Direct-mapped data cache, write-through, write-allocate.
// Loads hit in one cycle; stores merge into the line and
// write it to memory. Misaligned words raise opmFault.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module dataCache
	import l1memPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	cacheReq				req,
	input	logic					hold,
	output	logic [`WORD_WIDTH-1:0]	word,
	output	memOk					ok,
	output	lineReq					mem,
	input	lineRsp					memRsp
);

	typedef enum logic [2:0] {stIdle, stFill, stGap, stWrite, stFinish} dcState;

	dcState	state;

	logic [`DC_SETS-1:0]	validMem;
	logic [`ADDR_WIDTH-1:`LINE_OFFSET_BITS+`DC_INDEX_BITS]	tagMem [`DC_SETS];
	logic [`LINE_WIDTH-1:0]	lineMem [`DC_SETS];

	cacheReq					pend;		// access in flight
	logic [`LINE_WIDTH-1:0]		lineBuf;	// merged line for the write
	logic [`WORD_WIDTH-1:0]		finWord;
	memOk						finOk;
	logic						faultPend;	// one-cycle opmFault
	logic [`DC_INDEX_BITS-1:0]	lookIdx;
	logic [`DC_INDEX_BITS-1:0]	pendIdx;
	logic						lookHit;
	logic						reqMem;
	logic						reqAligned;
	logic						fillDone;
	logic						writeDone;

	// drop a word into its half of a line
	function automatic logic [`LINE_WIDTH-1:0] mergeWord(
		input logic [`LINE_WIDTH-1:0]	line,
		input logic						half,
		input logic [`WORD_WIDTH-1:0]	data
	);
		logic [`LINE_WIDTH-1:0] merged;
		merged = line;
		merged[half*`WORD_WIDTH +: `WORD_WIDTH] = data;
		return merged;
	endfunction

	assign lookIdx		= req.addr[`LINE_OFFSET_BITS +: `DC_INDEX_BITS];
	assign pendIdx		= pend.addr[`LINE_OFFSET_BITS +: `DC_INDEX_BITS];
	assign lookHit		= validMem[lookIdx] &&
		(tagMem[lookIdx] == req.addr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS+`DC_INDEX_BITS]);
	assign reqMem		= (req.opm == opmLoad) || (req.opm == opmStore);
	assign reqAligned	= (req.addr[2:0] == 3'b000);	// 8-byte words only
	assign fillDone		= (state == stFill) && (memRsp.ok == okDone);
	assign writeDone	= (state == stWrite) && (memRsp.ok == okDone);

	always_comb
	begin
		mem.addr	= {pend.addr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS], {`LINE_OFFSET_BITS{1'b0}}};
		mem.line	= lineBuf;
		case (state)
			stFill:		mem.opm = opmLoad;
			stWrite:	mem.opm = opmStore;
			default:	mem.opm = opmReady;	// gap cycle drops to ready
		endcase
		if (faultPend)	// full address, for the exception word
		begin
			mem.addr	= pend.addr;
			mem.opm		= opmFault;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state		<= stIdle;
			ok			<= okReady;
			faultPend	<= 1'b0;
			validMem	<= '0;
		end
		else
		begin
			faultPend <= 1'b0;
			case (state)
				stIdle:
					if (!hold)
					begin
						pend <= req;
						if (!reqMem)
							ok <= okReady;
						else if (!reqAligned)	// no line access, just the fault
						begin
							faultPend	<= 1'b1;
							ok			<= okFault;
						end
						else if (!lookHit)	// fill first, stores too
						begin
							ok		<= okHold;
							state	<= stFill;
						end
						else if (req.opm == opmLoad)
						begin
							word	<= lineMem[lookIdx][req.addr[`LINE_OFFSET_BITS-1]*`WORD_WIDTH +: `WORD_WIDTH];
							ok		<= okDone;
						end
						else
						begin
							lineBuf	<= mergeWord(lineMem[lookIdx], req.addr[`LINE_OFFSET_BITS-1], req.data);
							ok		<= okHold;
							state	<= stWrite;
						end
					end
				stFill:
					if (fillDone && pend.opm == opmStore)
					begin
						lineBuf	<= mergeWord(memRsp.line, pend.addr[`LINE_OFFSET_BITS-1], pend.data);
						state	<= stGap;
					end
					else if (fillDone)
					begin
						finWord	<= memRsp.line[pend.addr[`LINE_OFFSET_BITS-1]*`WORD_WIDTH +: `WORD_WIDTH];
						finOk	<= okDone;
						state	<= stFinish;
					end
					else if (memRsp.ok == okFault)
					begin
						finOk	<= okFault;
						state	<= stFinish;
					end
				stGap:
					state <= stWrite;	// one ready cycle between load and store
				stWrite:
					if (writeDone)
					begin
						finWord	<= pend.data;	// echo the stored word
						finOk	<= okDone;
						state	<= stFinish;
					end
					else if (memRsp.ok == okFault)	// array left untouched
					begin
						finOk	<= okFault;
						state	<= stFinish;
					end
				stFinish:
					if (!hold)
					begin
						if (finOk == okDone)
							word <= finWord;
						ok		<= finOk;
						state	<= stIdle;
					end
				default:
					state <= stIdle;
			endcase
			if ((fillDone && pend.opm == opmLoad) || writeDone)
				validMem[pendIdx] <= 1'b1;
		end
	end

	// array takes a load fill, or the merged line once memory has it
	always_ff @(posedge clock)
	begin
		if ((fillDone && pend.opm == opmLoad) || writeDone)
		begin
			lineMem[pendIdx]	<= writeDone ? lineBuf : memRsp.line;
			tagMem[pendIdx]		<= pend.addr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS+`DC_INDEX_BITS];
		end
	end

endmodule

// File: logic/instCache.sv
//**********************************************************
// Direct-mapped, read-only instruction cache.
// An address taken on one edge returns its 64-bit word on
// the next. A miss fills the line over the arbiter port.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module instCache
	import l1memPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic [`ADDR_WIDTH-1:0]	addr,
	input	logic					hold,
	output	logic [`WORD_WIDTH-1:0]	word,
	output	memOk					ok,
	output	lineReq					fill,
	input	lineRsp					fillRsp
);

	typedef enum logic [1:0] {stIdle, stFill, stFinish} icState;

	icState	state;

	logic [`IC_SETS-1:0]	validMem;
	logic [`ADDR_WIDTH-1:`LINE_OFFSET_BITS+`IC_INDEX_BITS]	tagMem [`IC_SETS];
	logic [`LINE_WIDTH-1:0]	lineMem [`IC_SETS];

	logic [`ADDR_WIDTH-1:0]		missAddr;	// address being filled
	logic [`WORD_WIDTH-1:0]		finWord;	// result parked until hold drops
	memOk						finOk;
	logic [`IC_INDEX_BITS-1:0]	lookIdx;
	logic [`IC_INDEX_BITS-1:0]	missIdx;
	logic						lookHit;
	logic						fillDone;

	assign lookIdx	= addr[`LINE_OFFSET_BITS +: `IC_INDEX_BITS];
	assign missIdx	= missAddr[`LINE_OFFSET_BITS +: `IC_INDEX_BITS];
	assign lookHit	= validMem[lookIdx] &&
		(tagMem[lookIdx] == addr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS+`IC_INDEX_BITS]);
	assign fillDone	= (state == stFill) && (fillRsp.ok == okDone);

	// line read request, held for the whole fill
	always_comb
	begin
		fill.addr	= {missAddr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS], {`LINE_OFFSET_BITS{1'b0}}};
		fill.opm	= (state == stFill) ? opmLoad : opmReady;
		fill.line	= '0;	// reads carry no data
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state		<= stIdle;
			ok			<= okReady;
			validMem	<= '0;
		end
		else
		begin
			case (state)
				stIdle:
					if (!hold)	// hold freezes word and ok
					begin
						missAddr <= addr;
						if (lookHit)
						begin
							word	<= lineMem[lookIdx][addr[`LINE_OFFSET_BITS-1]*`WORD_WIDTH +: `WORD_WIDTH];
							ok		<= okDone;
						end
						else
						begin
							ok		<= okHold;
							state	<= stFill;
						end
					end
				stFill:
					if (fillDone)
					begin
						validMem[missIdx]	<= 1'b1;
						finWord	<= fillRsp.line[missAddr[`LINE_OFFSET_BITS-1]*`WORD_WIDTH +: `WORD_WIDTH];
						finOk	<= okDone;
						state	<= stFinish;
					end
					else if (fillRsp.ok == okFault)	// refused or memory fault, no fill
					begin
						finOk	<= okFault;
						state	<= stFinish;
					end
				stFinish:
					if (!hold)
					begin
						if (finOk == okDone)
							word <= finWord;
						ok		<= finOk;
						state	<= stIdle;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	// line and tag arrays
	always_ff @(posedge clock)
	begin
		if (fillDone)
		begin
			lineMem[missIdx]	<= fillRsp.line;
			tagMem[missIdx]		<= missAddr[`ADDR_WIDTH-1:`LINE_OFFSET_BITS+`IC_INDEX_BITS];
		end
	end

endmodule

// File: logic/l1Arbiter.sv
//**********************************************************
// Shares the memory line port between the two caches.
// A grant is held until its transfer completes; fetch wins
// a tie. Refused accesses and faults go to a registered
// exception word, one cycle after the cause.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module l1Arbiter
	import l1memPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	lineReq					fetchReq,
	output	lineRsp					fetchRsp,
	input	lineReq					dataReq,
	output	lineRsp					dataRsp,
	input	accessFlags				flags,
	output	logic [`ADDR_WIDTH-1:0]	selAddr,
	output	lineReq					memReq,
	input	lineRsp					memRsp,
	output	excInfo					exc
);

	logic	latchIc;	// grant latches
	logic	latchDc;
	logic	nxtLatchIc;
	logic	nxtLatchDc;
	logic	icActive;
	logic	dcActive;
	logic	grantIc;
	logic	grantDc;
	logic	refuse;
	excInfo	excNext;

	assign icActive	= (fetchReq.opm != opmReady);
	assign dcActive	= (dataReq.opm == opmLoad) || (dataReq.opm == opmStore);	// opmFault never reaches memory
	assign grantIc	= (icActive && !latchDc) || latchIc;
	assign grantDc	= !grantIc && ((dcActive && !latchIc) || latchDc);
	assign selAddr	= grantDc ? dataReq.addr : fetchReq.addr;

	always_comb
	begin
		memReq		= '{addr: selAddr, opm: opmReady, line: '0};
		fetchRsp	= '{line: memRsp.line, ok: icActive ? okHold : okReady};	// loser waits
		dataRsp		= '{line: memRsp.line, ok: dcActive ? okHold : okReady};
		nxtLatchIc	= 1'b0;
		nxtLatchDc	= 1'b0;
		refuse		= 1'b0;
		excNext		= '0;

		if (dataReq.opm == opmFault)
			excNext = '{valid: 1'b1, code: misaligned, addr: dataReq.addr};

		if (grantIc)
		begin
			refuse		= icActive && flags.noExec;
			nxtLatchIc	= icActive || (memRsp.ok != okReady);	// keep until memory settles
			if (refuse)
			begin
				fetchRsp.ok	= okFault;
				excNext		= '{valid: 1'b1, code: fetchGuard, addr: fetchReq.addr};
			end
			else
			begin
				fetchRsp.ok	= memRsp.ok;
				memReq		= fetchReq;
			end
		end
		else if (grantDc)
		begin
			refuse		= ((dataReq.opm == opmLoad) && flags.noRead) ||
				((dataReq.opm == opmStore) && flags.noWrite);
			nxtLatchDc	= dcActive || (memRsp.ok != okReady);
			if (refuse)
			begin
				dataRsp.ok	= okFault;
				excNext		= '{valid: 1'b1, code: dataGuard, addr: dataReq.addr};
			end
			else
			begin
				dataRsp.ok	= memRsp.ok;
				memReq		= dataReq;
			end
		end

		// memory fault outranks everything else this cycle
		if (memRsp.ok == okFault)
			excNext = '{valid: 1'b1, code: memoryFault, addr: selAddr};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			latchIc	<= 1'b0;
			latchDc	<= 1'b0;
			exc		<= '0;
		end
		else
		begin
			latchIc	<= nxtLatchIc;
			latchDc	<= nxtLatchDc;
			exc		<= excNext;	// valid for one cycle only
		end
	end

endmodule

// File: logic/l1Memory.sv
//**********************************************************
// Top of the L1 memory subsystem: instruction and data
// caches sharing one 128-bit memory port through the
// arbiter, with the access guard beside it.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module l1Memory
	import l1memPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic [`ADDR_WIDTH-1:0]	fetchAddr,
	input	logic					fetchHold,
	output	logic [`WORD_WIDTH-1:0]	fetchWord,
	output	memOk					fetchOk,
	input	cacheReq				dataReq,
	input	logic					dataHold,
	output	logic [`WORD_WIDTH-1:0]	dataWord,
	output	memOk					dataOk,
	input	logic					cfgWrite,
	input	logic [1:0]				cfgIndex,	// 0 base, 1 limit, 2 flags
	input	logic [`ADDR_WIDTH-1:0]	cfgData,
	output	lineReq					memReq,
	input	lineRsp					memRsp,
	output	excInfo					exc
);

	lineReq					icFill;
	lineRsp					icRsp;
	lineReq					dcMem;
	lineRsp					dcRsp;
	accessFlags				guardFlags;
	logic [`ADDR_WIDTH-1:0]	selAddr;

	instCache icache (
		.clock		(clock),
		.reset		(reset),
		.addr		(fetchAddr),
		.hold		(fetchHold),
		.word		(fetchWord),
		.ok			(fetchOk),
		.fill		(icFill),
		.fillRsp	(icRsp)
	);

	dataCache dcache (
		.clock		(clock),
		.reset		(reset),
		.req		(dataReq),
		.hold		(dataHold),
		.word		(dataWord),
		.ok			(dataOk),
		.mem		(dcMem),
		.memRsp		(dcRsp)
	);

	l1Arbiter arbiter (
		.clock		(clock),
		.reset		(reset),
		.fetchReq	(icFill),
		.fetchRsp	(icRsp),
		.dataReq	(dcMem),
		.dataRsp	(dcRsp),
		.flags		(guardFlags),
		.selAddr	(selAddr),
		.memReq		(memReq),
		.memRsp		(memRsp),
		.exc		(exc)
	);

	accessGuard guard (
		.clock		(clock),
		.reset		(reset),
		.cfgWrite	(cfgWrite),
		.cfgIndex	(cfgIndex),
		.cfgData	(cfgData),
		.reqAddr	(selAddr),
		.flags		(guardFlags)
	);

endmodule

// File: logic/l1memPkg.sv
//**********************************************************
// Types of the L1 memory subsystem: operation and status
// codes, fault codes, and the structs passed between the
// caches, the arbiter, the guard and backing memory.
//**********************************************************
`include "l1mem_defs.svh"

package l1memPkg;

	typedef enum logic [2:0]
	{
		opmReady	= 3'b000,	// idle
		opmLoad		= 3'b001,	// line read
		opmStore	= 3'b010,	// line write
		opmFault	= 3'b111	// requester flags its own fault
	} memOpm;

	typedef enum logic [1:0]
	{
		okReady	= 2'b00,	// nothing pending
		okHold	= 2'b01,	// busy, try again
		okDone	= 2'b10,	// result valid this cycle
		okFault	= 2'b11
	} memOk;

	typedef enum logic [3:0]
	{
		memoryFault	= 4'h0,
		dataGuard	= 4'h1,
		misaligned	= 4'h2,
		fetchGuard	= 4'h3
	} faultCode;

	// word access from the core side
	typedef struct packed
	{
		logic [`ADDR_WIDTH-1:0]	addr;
		memOpm					opm;
		logic [`WORD_WIDTH-1:0]	data;	// store word, zero for fetch
	} cacheReq;

	// toward memory
	typedef struct packed
	{
		logic [`ADDR_WIDTH-1:0]	addr;
		memOpm					opm;
		logic [`LINE_WIDTH-1:0]	line;
	} lineReq;

	// back toward a cache
	typedef struct packed
	{
		logic [`LINE_WIDTH-1:0]	line;
		memOk					ok;
	} lineRsp;

	typedef struct packed
	{
		logic	noRead;
		logic	noWrite;
		logic	noExec;
	} accessFlags;

	typedef struct packed
	{
		logic					valid;
		faultCode				code;
		logic [`ADDR_WIDTH-1:0]	addr;	// faulting byte address
	} excInfo;

endpackage

// File: verification/backingStore.sv
//**********************************************************
// Backing memory for the L1 line port in the testbench.
// Answers each line read or write after 0 to 3 hold cycles
// and faults every line of a fixed region.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module backingStore
	import l1memPkg::*;
#(
	parameter int seedInit = 1
)
(
	input	logic	clock,
	input	logic	reset,
	input	lineReq	req,
	output	lineRsp	rsp
);

	localparam logic [`ADDR_WIDTH-1:0] faultBase	= 48'h3000;
	localparam logic [`ADDR_WIDTH-1:0] faultLimit	= 48'h3400;	// exclusive

	logic [`WORD_WIDTH-1:0]	written [logic [`ADDR_WIDTH-1:0]];	// words stored so far
	logic [`ADDR_WIDTH-1:0]	lineAddr;
	integer					seed = seedInit;
	int						remain = -1;	// hold cycles left, -1 when idle

	// contents before any write, tied to the full byte address
	function automatic logic [`WORD_WIDTH-1:0] resetWord(input logic [`ADDR_WIDTH-1:0] addr);
		return {addr[47:32] ^ 16'hD00D, addr[15:0] ^ 16'h3C3C, ~addr[31:0]};
	endfunction

	function automatic logic [`WORD_WIDTH-1:0] readWord(input logic [`ADDR_WIDTH-1:0] addr);
		if (written.exists(addr))
			return written[addr];
		return resetWord(addr);
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			rsp		<= '{line: '0, ok: okReady};
			remain	= -1;
		end
		else if (rsp.ok == okDone || rsp.ok == okFault)
			rsp.ok <= okReady;	// requester drops its request now
		else if (req.opm == opmLoad || req.opm == opmStore)
		begin
			if (remain < 0)
				remain = $unsigned($random(seed)) % 4;
			lineAddr = {req.addr[`ADDR_WIDTH-1:4], 4'h0};
			if (remain > 0)
			begin
				rsp.ok	<= okHold;
				remain	= remain - 1;
			end
			else if (lineAddr >= faultBase && lineAddr < faultLimit)
			begin
				rsp.ok	<= okFault;	// nothing read or written
				remain	= -1;
			end
			else
			begin
				if (req.opm == opmLoad)
					rsp.line <= {readWord(lineAddr + 8), readWord(lineAddr)};
				else
				begin
					written[lineAddr]		= req.line[63:0];
					written[lineAddr + 8]	= req.line[127:64];
				end
				rsp.ok	<= okDone;
				remain	= -1;
			end
		end
	end

endmodule

// File: verification/l1MemoryTb.sv
//**********************************************************
// Testbench for the L1 memory top level. Random fetches and
// data accesses run against a word model, then guard, fault
// and back-pressure cases. Compile it with the file list.
//**********************************************************
`timescale 1ns/1ns
`include "l1mem_defs.svh"

module l1MemoryTb
	import l1memPkg::*;
();

	localparam int randSeed		= 40793;
	localparam int nFetch		= 100;	// each one refetches the other half too
	localparam int nData		= 150;
	localparam int nPair		= 60;
	localparam int nDirected	= 20;
	localparam int opCount		= 2 * nFetch + nData + 2 * nPair + nDirected;
	localparam int cycleLimit	= opCount * 12;
	localparam int driveDelay	= 10;

	logic					clock;
	logic					reset;
	logic [`ADDR_WIDTH-1:0]	fetchAddr;
	logic					fetchHold;
	logic [`WORD_WIDTH-1:0]	fetchWord;
	memOk					fetchOk;
	cacheReq				dataReq;
	logic					dataHold;
	logic [`WORD_WIDTH-1:0]	dataWord;
	memOk					dataOk;
	logic					cfgWrite;
	logic [1:0]				cfgIndex;
	logic [`ADDR_WIDTH-1:0]	cfgData;
	lineReq					memReq;
	lineRsp					memRsp;
	excInfo					exc;

	logic [`WORD_WIDTH-1:0]	model [2048];	// words of 0x0000..0x3fff
	integer					seed = randSeed;
	excInfo					excSeen;		// last exception pulse
	int						excCount = 0;
	int						excCycle = 0;	// cycle of the last exception pulse
	int						memBusy = 0;	// cycles with a line request out
	int						cycleCount = 0;

	l1Memory uut (
		.clock		(clock),
		.reset		(reset),
		.fetchAddr	(fetchAddr),
		.fetchHold	(fetchHold),
		.fetchWord	(fetchWord),
		.fetchOk	(fetchOk),
		.dataReq	(dataReq),
		.dataHold	(dataHold),
		.dataWord	(dataWord),
		.dataOk		(dataOk),
		.cfgWrite	(cfgWrite),
		.cfgIndex	(cfgIndex),
		.cfgData	(cfgData),
		.memReq		(memReq),
		.memRsp		(memRsp),
		.exc		(exc)
	);

	backingStore #(.seedInit(randSeed)) store (
		.clock	(clock),
		.reset	(reset),
		.req	(memReq),
		.rsp	(memRsp)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// exc and the memory port, sampled away from the edges
	always @(negedge clock)
	begin
		if (exc.valid === 1'b1)
		begin
			excSeen = exc;
			excCycle = cycleCount;
			excCount++;
		end
		if (memReq.opm !== opmReady)
			memBusy++;
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			abortRun($sformatf("Timeout: tests not finished after %0d cycles", cycleLimit));
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkWord(input string name, input logic [`WORD_WIDTH-1:0] expected,
		input logic [`WORD_WIDTH-1:0] actual);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	task automatic checkOk(input string name, input memOk expected, input memOk actual);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0t ns: %s expected %s, got %s",
				$time, name, expected.name(), actual.name()));
	endtask

	task automatic checkExc(input excInfo expected, input excInfo actual);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0t ns: exc expected %b/%0d/%h, got %b/%0d/%h",
				$time, expected.valid, expected.code, expected.addr,
				actual.valid, actual.code, actual.addr));
	endtask

	function automatic logic [`WORD_WIDTH-1:0] initialWord(input logic [`ADDR_WIDTH-1:0] addr);
		return {addr[47:32] ^ 16'hD00D, addr[15:0] ^ 16'h3C3C, ~addr[31:0]};
	endfunction

	function automatic excInfo faultWord(input faultCode code, input logic [`ADDR_WIDTH-1:0] addr);
		return '{valid: 1'b1, code: code, addr: addr};
	endfunction

	// fetch region 0x0000..0x0fff, never written
	function automatic logic [`ADDR_WIDTH-1:0] fetchTarget();
		return 48'(($unsigned($random(seed)) % 'h200) << 3);
	endfunction

	// data region 0x1000..0x2fff, clear of the fault lines
	function automatic logic [`ADDR_WIDTH-1:0] dataTarget();
		return 48'h1000 + 48'(($unsigned($random(seed)) % 'h400) << 3);
	endfunction

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clock);
			#driveDelay;
		end
	endtask

	// lets any late pulse land, then checks what exc did
	task automatic settleExc(input excInfo expected);
		idleCycles(2);
		if (!expected.valid && excCount != 0)
			abortRun($sformatf("Unexpected exception at %0t ns, code %0d addr %h",
				$time, excSeen.code, excSeen.addr));
		if (expected.valid && excCount != 1)
			abortRun($sformatf("Expected one exception pulse by %0t ns, saw %0d",
				$time, excCount));
		if (expected.valid)
			checkExc(expected, excSeen);
		excCount = 0;
	endtask

	task automatic writeGuard(input logic [1:0] index, input logic [`ADDR_WIDTH-1:0] value);
		cfgWrite	= 1'b1;
		cfgIndex	= index;
		cfgData		= value;
		idleCycles(1);
		cfgWrite	= 1'b0;
	endtask

	task automatic fetchAccess(input logic [`ADDR_WIDTH-1:0] addr, input memOk expOk,
		output int latency);
		logic [`WORD_WIDTH-1:0] expWord;
		expWord		= model[addr[13:3]];
		fetchAddr	= addr;
		fetchHold	= 1'b0;
		latency		= 0;
		do
		begin
			@(posedge clock);
			#driveDelay;
			latency++;
		end
		while (fetchOk == okHold);
		fetchHold = 1'b1;	// park the result
		checkOk("fetchOk", expOk, fetchOk);
		if (expOk == okDone)
			checkWord("fetchWord", expWord, fetchWord);
	endtask

	task automatic dataAccess(input logic [`ADDR_WIDTH-1:0] addr, input memOpm opm,
		input logic [`WORD_WIDTH-1:0] data, input memOk expOk);
		logic [`WORD_WIDTH-1:0] expWord;
		expWord		= (opm == opmStore) ? data : model[addr[13:3]];	// stores echo the word
		dataReq		= '{addr: addr, opm: opm, data: data};
		dataHold	= 1'b0;
		do
		begin
			@(posedge clock);
			#driveDelay;
		end
		while (dataOk == okHold);
		dataHold	= 1'b1;
		dataReq.opm	= opmReady;
		checkOk("dataOk", expOk, dataOk);
		if (expOk == okDone)
		begin
			checkWord("dataWord", expWord, dataWord);
			if (opm == opmStore)
				model[addr[13:3]] = data;	// memory holds it now
		end
	endtask

	// both holds high while the addresses wander
	task automatic holdCheck(input int cycles);
		logic [`WORD_WIDTH-1:0]	keepFetch;
		logic [`WORD_WIDTH-1:0]	keepData;
		memOk					keepFetchOk;
		memOk					keepDataOk;
		keepFetch	= fetchWord;
		keepData	= dataWord;
		keepFetchOk	= fetchOk;
		keepDataOk	= dataOk;
		repeat (cycles)
		begin
			fetchAddr	= fetchTarget();
			dataReq		= '{addr: dataTarget(), opm: opmLoad, data: '0};
			idleCycles(1);
			checkWord("fetchWord", keepFetch, fetchWord);
			checkOk("fetchOk", keepFetchOk, fetchOk);
			checkWord("dataWord", keepData, dataWord);
			checkOk("dataOk", keepDataOk, dataOk);
		end
		dataReq.opm = opmReady;
	endtask

	initial
	begin
		int						latency;
		int						faultCycle;
		logic [`ADDR_WIDTH-1:0]	addr;
		logic [`ADDR_WIDTH-1:0]	dAddr;
		logic [`WORD_WIDTH-1:0]	value;
		memOpm					opm;
		accessFlags				winFlags;
		excInfo					noExc;

		noExc = '0;
		for (int i = 0; i < 2048; i++)
			model[i] = initialWord(48'(i * 8));
		reset		= 1'b1;
		fetchAddr	= '0;
		fetchHold	= 1'b1;
		dataReq		= '{addr: '0, opm: opmReady, data: '0};
		dataHold	= 1'b1;
		cfgWrite	= 1'b0;
		cfgIndex	= '0;
		cfgData		= '0;
		repeat (4) @(posedge clock);
		#driveDelay;
		reset = 1'b0;

		checkOk("fetchOk", okReady, fetchOk);
		checkOk("dataOk", okReady, dataOk);
		checkExc(noExc, exc);
		if (memReq.opm !== opmReady)
			abortRun("Memory request active right after reset");
		excCount = 0;

		// random fetches, the other half of the line must hit in one cycle
		for (int i = 0; i < nFetch; i++)
		begin
			addr = fetchTarget();
			fetchAccess(addr, okDone, latency);
			fetchAccess(addr ^ 48'h8, okDone, latency);
			if (latency != 1)
				abortRun($sformatf("Fetch of cached address %h took %0d cycles, not 1",
					addr ^ 48'h8, latency));
		end
		settleExc(noExc);

		for (int i = 0; i < nData; i++)
		begin
			addr	= dataTarget();
			value	= {$random(seed), $random(seed)};
			opm		= ($random(seed) & 1) ? opmStore : opmLoad;
			dataAccess(addr, opm, value, okDone);
		end
		settleExc(noExc);

		// both ports at once, fetch wins ties
		for (int i = 0; i < nPair; i++)
		begin
			addr	= fetchTarget();
			dAddr	= dataTarget();
			value	= {$random(seed), $random(seed)};
			opm		= ($random(seed) & 1) ? opmStore : opmLoad;
			fork
				fetchAccess(addr, okDone, latency);
				dataAccess(dAddr, opm, value, okDone);
			join
		end
		settleExc(noExc);

		// store, hit, evict through the same set, reload from memory
		dataAccess(48'h1238, opmStore, 64'hFEED_0123_4567_89AB, okDone);
		dataAccess(48'h1238, opmLoad, '0, okDone);
		dataAccess(48'h1638, opmLoad, '0, okDone);
		dataAccess(48'h1238, opmLoad, '0, okDone);
		settleExc(noExc);

		// noExec window over 0x0800..0x08ff
		winFlags = '{noRead: 1'b0, noWrite: 1'b0, noExec: 1'b1};
		writeGuard(2'd0, 48'h0800);
		writeGuard(2'd1, 48'h0900);
		writeGuard(2'd2, 48'(winFlags));
		fetchAccess(48'h0448, okDone, latency);	// evicts the set of 0x0848
		settleExc(noExc);
		fetchAccess(48'h0848, okFault, latency);
		settleExc(faultWord(fetchGuard, 48'h0840));

		// noWrite window over 0x2000..0x20ff
		winFlags = '{noRead: 1'b0, noWrite: 1'b1, noExec: 1'b0};
		writeGuard(2'd0, 48'h2000);
		writeGuard(2'd1, 48'h2100);
		writeGuard(2'd2, 48'(winFlags));
		dataAccess(48'h2088, opmStore, 64'h0BAD_0BAD_0BAD_0BAD, okFault);
		settleExc(faultWord(dataGuard, 48'h2080));
		dataAccess(48'h2488, opmLoad, '0, okDone);	// same set
		dataAccess(48'h2088, opmLoad, '0, okDone);	// old word still in memory
		settleExc(noExc);
		writeGuard(2'd1, 48'h0);	// empty window again

		dataAccess(48'h3048, opmLoad, '0, okFault);
		settleExc(faultWord(memoryFault, 48'h3040));
		fetchAccess(48'h3100, okFault, latency);
		settleExc(faultWord(memoryFault, 48'h3100));
		memBusy = 0;
		dataAccess(48'h1234, opmStore, 64'h1, okFault);
		faultCycle = cycleCount;	// cycle the cache raised opmFault
		settleExc(faultWord(misaligned, 48'h1234));
		if (memBusy != 0)
			abortRun("Misaligned store reached the memory port");
		if (excCycle != faultCycle + 1)
			abortRun($sformatf("Misaligned exception came %0d cycles after the fault, not 1",
				excCycle - faultCycle));

		fetchAccess(fetchTarget(), okDone, latency);
		dataAccess(dataTarget(), opmLoad, '0, okDone);
		holdCheck(5);
		settleExc(noExc);

		$display("*** PASSED ***");
		$finish;
	end

endmodule
